// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_req_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   wb_req_addr_i,
  input  logic [1:0]                   wb_req_size_i,
  input  logic [lsu_pkg::DATA_W-1:0]   wb_req_wdata_i,
  input  logic [lsu_pkg::DATA_W/8-1:0] wb_req_wstrobe_i,
  input  logic                         wb_req_wvalid_i,
  input  logic                         mh_req_valid_i,
  input  logic                         mh_req_write_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   mh_req_addr_i,
  input  logic [3:0]                   mh_req_burst_i,
  input  logic [1:0]                   mh_req_size_i,
  input  logic [lsu_pkg::DATA_W-1:0]   mh_req_wdata_i,
  input  logic                         mh_req_wvalid_i,
  input  logic                         mh_req_wlast_i,
  input  logic                         wb_busy_i,
  input  logic                         mh_active_i,
  input  logic                         bus_ready_i,
  output logic                         bus_valid_o,
  output logic                         bus_write_o,
  output logic [lsu_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic [3:0]                   bus_burst_o,
  output logic [1:0]                   bus_size_o,
  output logic [lsu_pkg::DATA_W-1:0]   bus_wdata_o,
  output logic [lsu_pkg::DATA_W/8-1:0] bus_wstrobe_o,
  output logic                         bus_wvalid_o,
  output logic                         bus_wlast_o,
  output logic                         mh_grant_o,
  output logic                         wb_hold_o
);

  logic owner_wb_q;

  assign mh_grant_o = !wb_busy_i;
  assign wb_hold_o = mh_active_i;

  // a running miss keeps the bus, otherwise stores win
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner_wb_q <= 1'b0;
    end else begin
      owner_wb_q <= !mh_active_i && wb_busy_i;
    end
  end

  always_comb begin
    bus_burst_o = lsu_pkg::BURST_LINE;
    bus_size_o = lsu_pkg::SIZE_WORD;
    bus_wstrobe_o = '1;
    if (owner_wb_q) begin
      bus_valid_o = wb_req_valid_i;
      bus_write_o = wb_req_valid_i;
      bus_addr_o = wb_req_addr_i;
      bus_wdata_o = wb_req_wdata_i;
      bus_wvalid_o = wb_req_wvalid_i;
      bus_wlast_o = wb_req_wvalid_i;
      if (wb_req_valid_i) begin
        bus_burst_o = lsu_pkg::BURST_SINGLE;
        bus_size_o = wb_req_size_i;
      end
      if (wb_req_wvalid_i) begin
        bus_wstrobe_o = wb_req_wstrobe_i;
      end
    end else begin
      bus_valid_o = mh_req_valid_i;
      bus_write_o = mh_req_write_i;
      bus_addr_o = mh_req_addr_i;
      bus_burst_o = mh_req_burst_i;
      bus_size_o = mh_req_size_i;
      bus_wdata_o = mh_req_wdata_i;
      bus_wvalid_o = mh_req_wvalid_i;
      bus_wlast_o = mh_req_wlast_i;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    bus_valid_o && !bus_ready_i |=> $stable(owner_wb_q));

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // line geometry
  localparam int LINE_WORDS = 4;
  localparam int TAG_W = 20;
  localparam int INDEX_W = 8;

  // uncached store queue depth
  localparam int WB_DEPTH = 4;

  // bus encodings
  localparam logic [3:0] BURST_LINE = 4'b0011;
  localparam logic [3:0] BURST_SINGLE = 4'b0000;
  localparam logic [1:0] SIZE_WORD = 2'b10;

  // physical address, raw or split into cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [INDEX_W-1:0] index;
      logic [1:0] word;
      logic [1:0] byte_sel;
    } f;
  } paddr_u;

endpackage

// ==== rtl/lsu_wport.sv ====
`timescale 1ns/10ps

module lsu_wport (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         st_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   st_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   st_data_i,
  input  logic [lsu_pkg::DATA_W/8-1:0] st_strobe_i,
  input  logic [1:0]                   st_size_i,
  output logic                         st_ready_o,
  input  logic                         mreq_valid_i,
  input  logic                         mreq_uncached_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   mreq_addr_i,
  input  logic [1:0]                   mreq_size_i,
  input  logic                         mreq_victim_valid_i,
  input  logic                         mreq_victim_dirty_i,
  input  logic [lsu_pkg::TAG_W-1:0]    mreq_victim_tag_i,
  output logic                         mreq_ready_o,
  output logic [lsu_pkg::INDEX_W+1:0]  victim_raddr_o,
  input  logic [lsu_pkg::DATA_W-1:0]   victim_rdata_i,
  output logic                         ram_we_o,
  output logic [lsu_pkg::INDEX_W+1:0]  ram_waddr_o,
  output logic [lsu_pkg::DATA_W-1:0]   ram_wdata_o,
  output logic                         tag_we_o,
  output logic [lsu_pkg::INDEX_W-1:0]  tag_waddr_o,
  output logic [lsu_pkg::TAG_W-1:0]    tag_wdata_o,
  output logic                         rd_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]   rd_data_o,
  output logic                         done_o,
  output logic                         bus_valid_o,
  output logic                         bus_write_o,
  output logic [lsu_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic [3:0]                   bus_burst_o,
  output logic [1:0]                   bus_size_o,
  output logic [lsu_pkg::DATA_W-1:0]   bus_wdata_o,
  output logic [lsu_pkg::DATA_W/8-1:0] bus_wstrobe_o,
  output logic                         bus_wvalid_o,
  output logic                         bus_wlast_o,
  input  logic                         bus_ready_i,
  input  logic                         bus_rvalid_i,
  input  logic                         bus_rlast_i,
  input  logic [lsu_pkg::DATA_W-1:0]   bus_rdata_i
);

  // store buffer request set
  logic wb_busy, wb_hold, wb_valid, wb_wvalid;
  logic [lsu_pkg::ADDR_W-1:0] wb_addr;
  logic [1:0] wb_size;
  logic [lsu_pkg::DATA_W-1:0] wb_wdata;
  logic [lsu_pkg::DATA_W/8-1:0] wb_wstrobe;

  // miss handler request set
  logic mh_grant, mh_active, mh_valid, mh_write, mh_wvalid, mh_wlast;
  logic [lsu_pkg::ADDR_W-1:0] mh_addr;
  logic [3:0] mh_burst;
  logic [1:0] mh_size;
  logic [lsu_pkg::DATA_W-1:0] mh_wdata;

  uncached_write_buffer wbuf0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .st_valid_i    (st_valid_i),
    .st_addr_i     (st_addr_i),
    .st_data_i     (st_data_i),
    .st_strobe_i   (st_strobe_i),
    .st_size_i     (st_size_i),
    .hold_i        (wb_hold),
    .bus_ready_i   (bus_ready_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .st_ready_o    (st_ready_o),
    .busy_o        (wb_busy),
    .req_valid_o   (wb_valid),
    .req_addr_o    (wb_addr),
    .req_size_o    (wb_size),
    .req_wdata_o   (wb_wdata),
    .req_wstrobe_o (wb_wstrobe),
    .req_wvalid_o  (wb_wvalid)
  );

  miss_handler mh0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .mreq_valid_i        (mreq_valid_i),
    .mreq_uncached_i     (mreq_uncached_i),
    .mreq_addr_i         (mreq_addr_i),
    .mreq_size_i         (mreq_size_i),
    .mreq_victim_valid_i (mreq_victim_valid_i),
    .mreq_victim_dirty_i (mreq_victim_dirty_i),
    .mreq_victim_tag_i   (mreq_victim_tag_i),
    .grant_i             (mh_grant),
    .victim_rdata_i      (victim_rdata_i),
    .bus_ready_i         (bus_ready_i),
    .bus_rvalid_i        (bus_rvalid_i),
    .bus_rlast_i         (bus_rlast_i),
    .bus_rdata_i         (bus_rdata_i),
    .mreq_ready_o        (mreq_ready_o),
    .active_o            (mh_active),
    .victim_raddr_o      (victim_raddr_o),
    .req_valid_o         (mh_valid),
    .req_write_o         (mh_write),
    .req_addr_o          (mh_addr),
    .req_burst_o         (mh_burst),
    .req_size_o          (mh_size),
    .req_wdata_o         (mh_wdata),
    .req_wvalid_o        (mh_wvalid),
    .req_wlast_o         (mh_wlast),
    .ram_we_o            (ram_we_o),
    .ram_waddr_o         (ram_waddr_o),
    .ram_wdata_o         (ram_wdata_o),
    .tag_we_o            (tag_we_o),
    .tag_waddr_o         (tag_waddr_o),
    .tag_wdata_o         (tag_wdata_o),
    .rd_valid_o          (rd_valid_o),
    .rd_data_o           (rd_data_o),
    .done_o              (done_o)
  );

  bus_arbiter arb0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .wb_req_valid_i   (wb_valid),
    .wb_req_addr_i    (wb_addr),
    .wb_req_size_i    (wb_size),
    .wb_req_wdata_i   (wb_wdata),
    .wb_req_wstrobe_i (wb_wstrobe),
    .wb_req_wvalid_i  (wb_wvalid),
    .mh_req_valid_i   (mh_valid),
    .mh_req_write_i   (mh_write),
    .mh_req_addr_i    (mh_addr),
    .mh_req_burst_i   (mh_burst),
    .mh_req_size_i    (mh_size),
    .mh_req_wdata_i   (mh_wdata),
    .mh_req_wvalid_i  (mh_wvalid),
    .mh_req_wlast_i   (mh_wlast),
    .wb_busy_i        (wb_busy),
    .mh_active_i      (mh_active),
    .bus_ready_i      (bus_ready_i),
    .bus_valid_o      (bus_valid_o),
    .bus_write_o      (bus_write_o),
    .bus_addr_o       (bus_addr_o),
    .bus_burst_o      (bus_burst_o),
    .bus_size_o       (bus_size_o),
    .bus_wdata_o      (bus_wdata_o),
    .bus_wstrobe_o    (bus_wstrobe_o),
    .bus_wvalid_o     (bus_wvalid_o),
    .bus_wlast_o      (bus_wlast_o),
    .mh_grant_o       (mh_grant),
    .wb_hold_o        (wb_hold)
  );

endmodule

// ==== rtl/miss_handler.sv ====
`timescale 1ns/10ps

module miss_handler (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 mreq_valid_i,
  input  logic                                 mreq_uncached_i,
  input  logic [lsu_pkg::ADDR_W-1:0]           mreq_addr_i,
  input  logic [1:0]                           mreq_size_i,
  input  logic                                 mreq_victim_valid_i,
  input  logic                                 mreq_victim_dirty_i,
  input  logic [lsu_pkg::TAG_W-1:0]            mreq_victim_tag_i,
  input  logic                                 grant_i,
  input  logic [lsu_pkg::DATA_W-1:0]           victim_rdata_i,
  input  logic                                 bus_ready_i,
  input  logic                                 bus_rvalid_i,
  input  logic                                 bus_rlast_i,
  input  logic [lsu_pkg::DATA_W-1:0]           bus_rdata_i,
  output logic                                 mreq_ready_o,
  output logic                                 active_o,
  output logic [lsu_pkg::INDEX_W+1:0]          victim_raddr_o,
  output logic                                 req_valid_o,
  output logic                                 req_write_o,
  output logic [lsu_pkg::ADDR_W-1:0]           req_addr_o,
  output logic [3:0]                           req_burst_o,
  output logic [1:0]                           req_size_o,
  output logic [lsu_pkg::DATA_W-1:0]           req_wdata_o,
  output logic                                 req_wvalid_o,
  output logic                                 req_wlast_o,
  output logic                                 ram_we_o,
  output logic [lsu_pkg::INDEX_W+1:0]          ram_waddr_o,
  output logic [lsu_pkg::DATA_W-1:0]           ram_wdata_o,
  output logic                                 tag_we_o,
  output logic [lsu_pkg::INDEX_W-1:0]          tag_waddr_o,
  output logic [lsu_pkg::TAG_W-1:0]            tag_wdata_o,
  output logic                                 rd_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]           rd_data_o,
  output logic                                 done_o
);

  localparam logic [3:0] S_IDLE = 4'd0;
  localparam logic [3:0] S_GRANT = 4'd1;
  localparam logic [3:0] S_WB_ADDR = 4'd2;
  localparam logic [3:0] S_WB_DATA = 4'd3;
  localparam logic [3:0] S_RF_ADDR = 4'd4;
  localparam logic [3:0] S_RF_DATA = 4'd5;
  localparam logic [3:0] S_PT_ADDR = 4'd6;
  localparam logic [3:0] S_PT_DATA = 4'd7;
  localparam logic [3:0] S_TAG = 4'd8;
  localparam logic [2:0] PF_DONE = 3'(lsu_pkg::LINE_WORDS + 1);

  logic [3:0] state_q, state_d;
  lsu_pkg::paddr_u addr_q;
  logic uncached_q;
  logic [1:0] size_q;
  logic dirty_q;
  logic [lsu_pkg::TAG_W-1:0] vtag_q;
  logic [2:0] pf_cnt_q;
  logic [1:0] beat_q;
  logic [lsu_pkg::DATA_W-1:0] lbuf_q [lsu_pkg::LINE_WORDS];
  logic accept, line_ready, wbeat, pt_beat;

  assign mreq_ready_o = state_q == S_IDLE;
  assign accept = mreq_valid_i && mreq_ready_o;
  // granted and running a bus transaction
  assign active_o = state_q != S_IDLE && state_q != S_GRANT;
  assign line_ready = pf_cnt_q == PF_DONE;
  assign wbeat = req_wvalid_o && bus_rvalid_i;
  assign pt_beat = state_q == S_PT_DATA && bus_rvalid_i;

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q.raw <= mreq_addr_i;
      uncached_q <= mreq_uncached_i;
      size_q <= mreq_size_i;
      dirty_q <= mreq_victim_valid_i && mreq_victim_dirty_i;
      vtag_q <= mreq_victim_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      pf_cnt_q <= '0;
      beat_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        pf_cnt_q <= '0;
        beat_q <= '0;
      end else begin
        // victim prefetch runs ahead of the writeback data phase
        if (state_q != S_IDLE && dirty_q && !line_ready) begin
          pf_cnt_q <= pf_cnt_q + 3'd1;
        end
        if (wbeat || ram_we_o) begin
          beat_q <= beat_q + 2'd1;
        end
      end
    end
  end

  // read data lags the address by one cycle
  always_ff @(posedge clk) begin
    if (pf_cnt_q != 3'd0 && !line_ready) begin
      lbuf_q[pf_cnt_q[1:0] - 2'd1] <= victim_rdata_i;
    end
  end

  assign victim_raddr_o = {addr_q.f.index, pf_cnt_q[1:0]};

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          state_d = S_GRANT;
        end
      end
      S_GRANT: begin
        if (grant_i) begin
          if (uncached_q) begin
            state_d = S_PT_ADDR;
          end else if (dirty_q) begin
            state_d = S_WB_ADDR;
          end else begin
            state_d = S_RF_ADDR;
          end
        end
      end
      S_WB_ADDR: begin
        if (bus_ready_i) begin
          state_d = S_WB_DATA;
        end
      end
      S_WB_DATA: begin
        if (wbeat && req_wlast_o) begin
          state_d = S_RF_ADDR;
        end
      end
      S_RF_ADDR: begin
        if (bus_ready_i) begin
          state_d = S_RF_DATA;
        end
      end
      S_RF_DATA: begin
        if (bus_rvalid_i && bus_rlast_i) begin
          state_d = S_TAG;
        end
      end
      S_PT_ADDR: begin
        if (bus_ready_i) begin
          state_d = S_PT_DATA;
        end
      end
      S_PT_DATA: begin
        if (bus_rvalid_i) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  assign req_valid_o = state_q == S_WB_ADDR || state_q == S_RF_ADDR || state_q == S_PT_ADDR;
  assign req_write_o = state_q == S_WB_ADDR;

  always_comb begin
    req_addr_o = {addr_q.f.tag, addr_q.f.index, 4'b0000};
    if (state_q == S_WB_ADDR) begin
      req_addr_o = {vtag_q, addr_q.f.index, 4'b0000};
    end else if (state_q == S_PT_ADDR) begin
      req_addr_o = addr_q.raw;
    end
  end

  assign req_burst_o = (state_q == S_PT_ADDR) ? lsu_pkg::BURST_SINGLE : lsu_pkg::BURST_LINE;
  assign req_size_o = (state_q == S_PT_ADDR) ? size_q : lsu_pkg::SIZE_WORD;
  assign req_wdata_o = lbuf_q[beat_q];
  assign req_wvalid_o = state_q == S_WB_DATA && line_ready;
  assign req_wlast_o = req_wvalid_o && beat_q == 2'd3;

  // refill beats land at the word counter
  assign ram_we_o = state_q == S_RF_DATA && bus_rvalid_i;
  assign ram_waddr_o = {addr_q.f.index, beat_q};
  assign ram_wdata_o = bus_rdata_i;

  assign tag_we_o = state_q == S_TAG;
  assign tag_waddr_o = addr_q.f.index;
  assign tag_wdata_o = addr_q.f.tag;

  assign rd_valid_o = (ram_we_o && beat_q == addr_q.f.word) || pt_beat;
  assign rd_data_o = bus_rdata_i;
  assign done_o = tag_we_o || pt_beat;

  assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_we_o && tag_we_o));

  assert property (@(posedge clk) disable iff (!rst_n)
    state_q <= S_TAG);

endmodule

// ==== rtl/uncached_write_buffer.sv ====
`timescale 1ns/10ps

module uncached_write_buffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         st_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   st_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   st_data_i,
  input  logic [lsu_pkg::DATA_W/8-1:0] st_strobe_i,
  input  logic [1:0]                   st_size_i,
  input  logic                         hold_i,
  input  logic                         bus_ready_i,
  input  logic                         bus_rvalid_i,
  output logic                         st_ready_o,
  output logic                         busy_o,
  output logic                         req_valid_o,
  output logic [lsu_pkg::ADDR_W-1:0]   req_addr_o,
  output logic [1:0]                   req_size_o,
  output logic [lsu_pkg::DATA_W-1:0]   req_wdata_o,
  output logic [lsu_pkg::DATA_W/8-1:0] req_wstrobe_o,
  output logic                         req_wvalid_o
);

  localparam logic [1:0] S_EMPTY = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;

  logic [1:0] state_q, state_d;
  logic [2:0] wr_ptr_q, rd_ptr_q, count;
  logic [1:0] head;
  logic push, pop, full;

  lsu_pkg::paddr_u addr_mem [lsu_pkg::WB_DEPTH];
  logic [lsu_pkg::DATA_W-1:0] data_mem [lsu_pkg::WB_DEPTH];
  logic [lsu_pkg::DATA_W/8-1:0] strobe_mem [lsu_pkg::WB_DEPTH];
  logic [1:0] size_mem [lsu_pkg::WB_DEPTH];

  assign count = wr_ptr_q - rd_ptr_q;
  assign full = count == 3'(lsu_pkg::WB_DEPTH);
  assign head = rd_ptr_q[1:0];
  assign st_ready_o = !full;
  assign push = st_valid_i && !full;
  // entry leaves the queue once its data beat is taken
  assign pop = state_q == S_DATA && bus_rvalid_i;
  assign busy_o = state_q != S_EMPTY || count != 3'd0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      state_q <= S_EMPTY;
    end else begin
      state_q <= state_d;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 3'd1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr_q[1:0]].raw <= st_addr_i;
      data_mem[wr_ptr_q[1:0]] <= st_data_i;
      strobe_mem[wr_ptr_q[1:0]] <= st_strobe_i;
      size_mem[wr_ptr_q[1:0]] <= st_size_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_ADDR: begin
        if (bus_ready_i) begin
          state_d = S_DATA;
        end
      end
      S_DATA: begin
        // go straight on if more than the current entry is queued
        if (bus_rvalid_i) begin
          state_d = (count > 3'd1) ? S_ADDR : S_EMPTY;
        end
      end
      default: begin
        if (count != 3'd0 && !hold_i) begin
          state_d = S_ADDR;
        end
      end
    endcase
  end

  assign req_valid_o = state_q == S_ADDR;
  assign req_addr_o = addr_mem[head].raw;
  assign req_size_o = size_mem[head];
  assign req_wdata_o = data_mem[head];
  assign req_wstrobe_o = strobe_mem[head];
  assign req_wvalid_o = state_q == S_DATA;

  assert property (@(posedge clk) disable iff (!rst_n)
    count <= 3'(lsu_pkg::WB_DEPTH));

  assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_o && !bus_ready_i |=> req_valid_o);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_lsu_wport -o tb_lsu_wport &&
./obj_dir/tb_lsu_wport || {
  echo "simulation failed"
  exit 1
}

// ==== sim.f ====
rtl/lsu_pkg.sv
rtl/uncached_write_buffer.sv
rtl/miss_handler.sv
rtl/bus_arbiter.sv
rtl/lsu_wport.sv
testbench/tb_lsu_wport.sv

// ==== testbench/lsu_testdata.txt ====
# kind addr data strobe size victim_valid victim_dirty victim_tag expect (all hex)
# kind 1 store, 2 cached miss, 3 uncached read, 4 hold bus, 5 check st_ready, 6 release, 7 sync
1 00001000 deadbeef f 2 0 0 0 deadbeef
7 0 0 0 0 0 0 0 0
# five stores against a stalled bus
4 0 0 0 0 0 0 0 0
1 00002000 11111111 f 2 0 0 0 11111111
1 00002004 22222222 3 1 0 0 0 22222222
1 00002008 33333333 f 2 0 0 0 33333333
1 0000200c 44444444 f 2 0 0 0 44444444
5 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0
1 00002010 55555555 f 2 0 0 0 55555555
7 0 0 0 0 0 0 0 0
# refill with a clean victim
2 12345678 0 0 2 1 0 abcde 486e5678
7 0 0 0 0 0 0 0 0
# refill with an invalid victim marked dirty
2 00fff3fc 0 0 2 0 1 12345 5aa5f3fc
7 0 0 0 0 0 0 0 0
# refill behind a dirty victim writeback
2 0009a104 0 0 2 1 1 7f00d 5a53a104
7 0 0 0 0 0 0 0 0
# uncached read on its own
3 80000024 0 0 1 0 0 0 da5a0024
7 0 0 0 0 0 0 0 0
# uncached read queued behind stores
4 0 0 0 0 0 0 0 0
1 00003000 aaaa5555 f 2 0 0 0 aaaa5555
1 00003004 0000beef c 2 0 0 0 0000beef
3 80000010 0 0 2 0 0 0 da5a0010
6 0 0 0 0 0 0 0 0
7 0 0 0 0 0 0 0 0

// ==== testbench/tb_lsu_wport.sv ====
`timescale 1ns/10ps

module tb_lsu_wport;

  localparam logic [31:0] READ_MASK = 32'h5a5a_0000;
  localparam logic [31:0] VICTIM_MASK = 32'hc0de_0000;
  localparam int TIMEOUT = 200;
  localparam logic [1:0] B_IDLE = 2'd0;
  localparam logic [1:0] B_ADDR = 2'd1;
  localparam logic [1:0] B_READ = 2'd2;
  localparam logic [1:0] B_WRITE = 2'd3;

  logic clk, rst_n;
  logic st_valid_i, st_ready_o;
  logic [31:0] st_addr_i, st_data_i;
  logic [3:0] st_strobe_i;
  logic [1:0] st_size_i;
  logic mreq_valid_i, mreq_uncached_i, mreq_victim_valid_i, mreq_victim_dirty_i;
  logic [31:0] mreq_addr_i;
  logic [1:0] mreq_size_i;
  logic [19:0] mreq_victim_tag_i;
  logic mreq_ready_o;
  logic [9:0] victim_raddr_o;
  logic [31:0] victim_rdata_i;
  logic ram_we_o, tag_we_o, rd_valid_o, done_o;
  logic [9:0] ram_waddr_o;
  logic [31:0] ram_wdata_o, rd_data_o;
  logic [7:0] tag_waddr_o;
  logic [19:0] tag_wdata_o;
  logic bus_valid_o, bus_write_o, bus_wvalid_o, bus_wlast_o;
  logic [31:0] bus_addr_o, bus_wdata_o;
  logic [3:0] bus_burst_o, bus_wstrobe_o;
  logic [1:0] bus_size_o;
  logic bus_ready_i, bus_rvalid_i, bus_rlast_i;
  logic [31:0] bus_rdata_i;

  // expected traffic queues in arrival order
  logic [38:0] exp_req [$];
  logic [36:0] exp_wbeat [$];
  logic [41:0] exp_ram [$];
  logic [27:0] exp_tag [$];
  logic [31:0] exp_rd [$];
  int done_exp, done_seen;

  // bus model state
  logic bus_hold;
  logic [1:0] bstate;
  int dly, beat_idx, beat_total;
  logic [31:0] baddr, seed_val;
  logic [9:0] vraddr_q;

  lsu_wport dut0 (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic accept_request;
    logic [38:0] e;
    if (exp_req.size() == 0) begin
      abort_run("bus request seen while none was expected");
    end else begin
      e = exp_req.pop_front();
      check_value("bus_write_o", 32'(bus_write_o), 32'(e[38]));
      check_value("bus_burst_o", 32'(bus_burst_o), 32'(e[37:34]));
      check_value("bus_size_o", 32'(bus_size_o), 32'(e[33:32]));
      check_value("bus_addr_o", bus_addr_o, e[31:0]);
      bus_ready_i = 1'b1;
      baddr = bus_addr_o;
      beat_idx = 0;
      beat_total = (bus_burst_o == lsu_pkg::BURST_LINE) ? lsu_pkg::LINE_WORDS : 1;
      dly = int'($urandom % 4);
      bstate = bus_write_o ? B_WRITE : B_READ;
    end
  endtask

  task automatic send_read_beat;
    bus_rvalid_i = 1'b1;
    bus_rdata_i = (baddr + 32'(beat_idx * 4)) ^ READ_MASK;
    bus_rlast_i = beat_idx == beat_total - 1;
    beat_idx++;
    dly = int'($urandom % 4);
    if (beat_idx == beat_total) begin
      bstate = B_IDLE;
    end
  endtask

  task automatic take_write_beat;
    logic [36:0] e;
    if (exp_wbeat.size() == 0) begin
      abort_run("bus write beat seen while none was expected");
    end else begin
      e = exp_wbeat.pop_front();
      check_value("bus_wdata_o", bus_wdata_o, e[31:0]);
      check_value("bus_wstrobe_o", 32'(bus_wstrobe_o), 32'(e[35:32]));
      check_value("bus_wlast_o", 32'(bus_wlast_o), 32'(e[36]));
      bus_rvalid_i = 1'b1;
      dly = int'($urandom % 4);
      if (bus_wlast_o) begin
        bstate = B_IDLE;
      end
    end
  endtask

  // bus slave and victim RAM answer on the falling edge
  always @(negedge clk) begin
    bus_ready_i = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rlast_i = 1'b0;
    victim_rdata_i = {22'd0, vraddr_q} ^ VICTIM_MASK;
    vraddr_q = victim_raddr_o;
    if (!rst_n) begin
      bstate = B_IDLE;
    end else begin
      if (bstate == B_IDLE && bus_valid_o) begin
        dly = int'($urandom % 4);
        bstate = B_ADDR;
      end
      if (bstate == B_ADDR) begin
        if (!bus_hold) begin
          if (dly == 0) begin
            accept_request();
          end else begin
            dly--;
          end
        end
      end else if (bstate == B_READ) begin
        if (dly == 0) begin
          send_read_beat();
        end else begin
          dly--;
        end
      end else if (bstate == B_WRITE && bus_wvalid_o) begin
        if (dly == 0) begin
          take_write_beat();
        end else begin
          dly--;
        end
      end
    end
  end

  task automatic check_outputs;
    logic [41:0] r;
    logic [27:0] t;
    if (ram_we_o) begin
      if (exp_ram.size() == 0) begin
        abort_run("data RAM write seen while none was expected");
      end else begin
        r = exp_ram.pop_front();
        check_value("ram_waddr_o", 32'(ram_waddr_o), 32'(r[41:32]));
        check_value("ram_wdata_o", ram_wdata_o, r[31:0]);
      end
    end
    if (tag_we_o) begin
      if (exp_tag.size() == 0) begin
        abort_run("tag write seen while none was expected");
      end else begin
        t = exp_tag.pop_front();
        check_value("tag_waddr_o", 32'(tag_waddr_o), 32'(t[27:20]));
        check_value("tag_wdata_o", 32'(tag_wdata_o), 32'(t[19:0]));
        check_value("done_o", 32'(done_o), 32'd1);
      end
    end
    if (rd_valid_o) begin
      if (exp_rd.size() == 0) begin
        abort_run("read data returned while none was expected");
      end else begin
        check_value("rd_data_o", rd_data_o, exp_rd.pop_front());
      end
    end
    if (done_o) begin
      if (done_seen >= done_exp) begin
        abort_run("done pulse seen with no operation outstanding");
      end else begin
        done_seen++;
      end
    end
  endtask

  // outputs settle after the bus model has driven
  always @(negedge clk) begin
    #2;
    if (rst_n) begin
      check_outputs();
    end
  end

  task automatic expect_store(input logic [31:0] addr, input logic [3:0] strobe,
                              input logic [1:0] size, input logic [31:0] data);
    exp_req.push_back({1'b1, lsu_pkg::BURST_SINGLE, size, addr});
    exp_wbeat.push_back({1'b1, strobe, data});
  endtask

  task automatic expect_miss(input logic [31:0] addr, input logic dirty,
                             input logic [19:0] vtag, input logic [31:0] rd_word);
    lsu_pkg::paddr_u pa;
    logic [31:0] line_addr;
    int w;
    pa.raw = addr;
    line_addr = {pa.f.tag, pa.f.index, 4'b0000};
    if (dirty) begin
      exp_req.push_back({1'b1, lsu_pkg::BURST_LINE, lsu_pkg::SIZE_WORD,
                         vtag, pa.f.index, 4'b0000});
      for (w = 0; w < 4; w++) begin
        exp_wbeat.push_back({w == 3, 4'hf, {22'd0, pa.f.index, 2'(w)} ^ VICTIM_MASK});
      end
    end
    exp_req.push_back({1'b0, lsu_pkg::BURST_LINE, lsu_pkg::SIZE_WORD, line_addr});
    for (w = 0; w < 4; w++) begin
      exp_ram.push_back({pa.f.index, 2'(w), (line_addr | 32'(w * 4)) ^ READ_MASK});
    end
    exp_tag.push_back({pa.f.index, pa.f.tag});
    exp_rd.push_back(rd_word);
    done_exp++;
  endtask

  task automatic drive_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strobe, input logic [1:0] size);
    int n;
    n = 0;
    st_valid_i = 1'b1;
    st_addr_i = addr;
    st_data_i = data;
    st_strobe_i = strobe;
    st_size_i = size;
    while (!st_ready_o) begin
      @(negedge clk);
      n++;
      if (n >= TIMEOUT) begin
        abort_run("timeout waiting for the store buffer to accept a store");
      end
    end
    @(negedge clk);
    st_valid_i = 1'b0;
  endtask

  task automatic drive_miss(input logic [31:0] addr, input logic uncached, input logic [1:0] size,
                            input logic vvalid, input logic vdirty, input logic [19:0] vtag);
    int n;
    n = 0;
    mreq_valid_i = 1'b1;
    mreq_uncached_i = uncached;
    mreq_addr_i = addr;
    mreq_size_i = size;
    mreq_victim_valid_i = vvalid;
    mreq_victim_dirty_i = vdirty;
    mreq_victim_tag_i = vtag;
    while (!mreq_ready_o) begin
      @(negedge clk);
      n++;
      if (n >= TIMEOUT) begin
        abort_run("timeout waiting for the miss handler to accept a request");
      end
    end
    @(negedge clk);
    mreq_valid_i = 1'b0;
  endtask

  function automatic logic all_done();
    return exp_req.size() == 0 && exp_wbeat.size() == 0 && exp_ram.size() == 0 &&
           exp_tag.size() == 0 && exp_rd.size() == 0 && done_seen == done_exp &&
           bstate == B_IDLE && mreq_ready_o;
  endfunction

  task automatic wait_idle;
    int n;
    n = 0;
    @(negedge clk);
    #3;
    while (!all_done()) begin
      @(negedge clk);
      #3;
      n++;
      if (n >= TIMEOUT) begin
        abort_run("timeout waiting for outstanding operations to finish");
      end
    end
    @(negedge clk);
  endtask

  initial begin
    string line;
    int fd, n;
    logic [31:0] kind, addr, data, strobe, size, vv, vd, vtag, expv;
    seed_val = $urandom(32'h8d30);
    rst_n = 1'b0;
    st_valid_i = 1'b0;
    st_addr_i = '0;
    st_data_i = '0;
    st_strobe_i = '0;
    st_size_i = '0;
    mreq_valid_i = 1'b0;
    mreq_uncached_i = 1'b0;
    mreq_addr_i = '0;
    mreq_size_i = '0;
    mreq_victim_valid_i = 1'b0;
    mreq_victim_dirty_i = 1'b0;
    mreq_victim_tag_i = '0;
    victim_rdata_i = '0;
    bus_ready_i = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rlast_i = 1'b0;
    bus_rdata_i = '0;
    bus_hold = 1'b0;
    bstate = B_IDLE;
    done_exp = 0;
    done_seen = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("st_ready_o", 32'(st_ready_o), 32'd1);
    check_value("mreq_ready_o", 32'(mreq_ready_o), 32'd1);
    check_value("bus_valid_o", 32'(bus_valid_o), 32'd0);
    check_value("bus_wvalid_o", 32'(bus_wvalid_o), 32'd0);
    check_value("ram_we_o", 32'(ram_we_o), 32'd0);
    check_value("tag_we_o", 32'(tag_we_o), 32'd0);
    check_value("rd_valid_o", 32'(rd_valid_o), 32'd0);
    check_value("done_o", 32'(done_o), 32'd0);

    fd = $fopen("testbench/lsu_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/lsu_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    kind, addr, data, strobe, size, vv, vd, vtag, expv);
        if (n != 9) begin
          abort_run("malformed line in the data file");
        end
        case (kind)
          32'd1: begin
            expect_store(addr, strobe[3:0], size[1:0], expv);
            drive_store(addr, data, strobe[3:0], size[1:0]);
          end
          32'd2: begin
            check_value("data file read word", expv, addr ^ READ_MASK);
            expect_miss(addr, vv[0] && vd[0], vtag[19:0], expv);
            drive_miss(addr, 1'b0, size[1:0], vv[0], vd[0], vtag[19:0]);
          end
          32'd3: begin
            check_value("data file read word", expv, addr ^ READ_MASK);
            exp_req.push_back({1'b0, lsu_pkg::BURST_SINGLE, size[1:0], addr});
            exp_rd.push_back(expv);
            done_exp++;
            drive_miss(addr, 1'b1, size[1:0], 1'b0, 1'b0, 20'd0);
          end
          32'd4: bus_hold = 1'b1;
          32'd5: check_value("st_ready_o", 32'(st_ready_o), expv);
          32'd6: bus_hold = 1'b0;
          32'd7: wait_idle();
          default: abort_run("unknown operation kind in the data file");
        endcase
      end
    end
    $fclose(fd);
    wait_idle();
    $display(">>> PASS");
    $finish;
  end

endmodule
